//--- dv/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic Clk,
    output logic rstN
);

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // Reset held for five rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
    end

endmodule

//--- dv/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;

    localparam logic [31:0] randSeed = 32'h7a1efea8;
    localparam int timeoutMargin = 20;
    localparam int memDepth = 256;

    // Opcodes and funcs of the instruction set
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [15:0] hltInstr = 16'hF01D;

    logic        Clk;
    logic        rstN;
    logic        imemRead;
    logic [15:0] imemAddr;
    logic [15:0] imemData;
    logic        dmemRead;
    logic        dmemWrite;
    logic [15:0] dmemAddr;
    logic [15:0] dmemWdata;
    logic [15:0] dmemRdata;
    logic        halted;
    logic [15:0] numInst;
    logic [15:0] outputPort;

    logic [15:0] imem [memDepth];
    logic [15:0] dmem [memDepth];
    logic [15:0] initData [memDepth];
    logic [15:0] shadow [memDepth];
    logic        memReady = 1'b0;

    // Program table
    logic [15:0] progInstr [$];
    bit          progRetires [$];
    bit          progWwd [$];
    logic [15:0] progExpect [$];
    logic [15:0] wwdExpected [$];

    logic [7:0]  ldAddr;
    logic [7:0]  stAddr;
    int          retiredCount = 0;
    int          timeoutLimit = 1000;
    int          cycles = 0;
    int          wwdSeen = 0;
    logic [15:0] lastPort = 16'h0;

    clockGen i_clockGen (
        .Clk  (Clk),
        .rstN (rstN)
    );

    cpuTop i_cpuTop (
        .Clk        (Clk),
        .rstN       (rstN),
        .imemRead   (imemRead),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .dmemRead   (dmemRead),
        .dmemWrite  (dmemWrite),
        .dmemAddr   (dmemAddr),
        .dmemWdata  (dmemWdata),
        .dmemRdata  (dmemRdata),
        .halted     (halted),
        .numInst    (numInst),
        .outputPort (outputPort)
    );

    assign imemData = imem[imemAddr[7:0]];
    assign dmemRdata = dmem[dmemAddr[7:0]];

    // Data memory, writes land on the rising edge
    initial begin
        wait (memReady);
        for (int i = 0; i < memDepth; i++) begin
            dmem[i] <= initData[i];
        end
        forever begin
            @(posedge Clk);
            if (dmemWrite) begin
                dmem[dmemAddr[7:0]] <= dmemWdata;
            end
        end
    end

    function automatic logic [15:0] encodeRtype(input logic [1:0] rs, input logic [1:0] rt,
                                                input logic [1:0] rd, input logic [5:0] func);
        return {4'hF, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] encodeItype(input logic [3:0] op, input logic [1:0] rs,
                                                input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        if (got !== expected) begin
            failRun($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                              $time, name, got, expected));
        end
    endtask

    task automatic addRow(input logic [15:0] instr, input bit retires, input bit isWwd,
                          input logic [15:0] expected);
        progInstr.push_back(instr);
        progRetires.push_back(retires);
        progWwd.push_back(isWwd);
        progExpect.push_back(expected);
    endtask

    task automatic buildProgram();
        logic [15:0] loaded;
        logic [15:0] stored;
        // r1=0034 r2=002D r3=0061 r1=FFCC r2=000C r3=006D
        addRow(encodeItype(opAdi, 2'd0, 2'd1, 8'h34), 1'b1, 1'b0, 16'h0);
        addRow(encodeItype(opAdi, 2'd1, 2'd2, 8'hF9), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd1, 2'd2, 2'd3, fnAdd), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd2, 2'd3, 2'd1, fnSub), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd1, 2'd2, 2'd2, fnAnd), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd2, 2'd3, 2'd3, fnOrr), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd1, 2'd0, 2'd0, fnWwd), 1'b1, 1'b1, 16'hFFCC);
        addRow(encodeRtype(2'd2, 2'd0, 2'd0, fnWwd), 1'b1, 1'b1, 16'h000C);
        addRow(encodeRtype(2'd3, 2'd0, 2'd0, fnWwd), 1'b1, 1'b1, 16'h006D);
        // Load followed at once by its use
        loaded = shadow[ldAddr];
        addRow(encodeItype(opLwd, 2'd0, 2'd1, ldAddr), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd1, 2'd3, 2'd2, fnAdd), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd2, 2'd0, 2'd0, fnWwd), 1'b1, 1'b1, loaded + 16'h006D);
        // Store then reload
        stored = loaded + 16'h007E;
        shadow[stAddr] = stored;
        addRow(encodeItype(opAdi, 2'd2, 2'd3, 8'h11), 1'b1, 1'b0, 16'h0);
        addRow(encodeItype(opSwd, 2'd0, 2'd3, stAddr), 1'b1, 1'b0, 16'h0);
        addRow(encodeItype(opLwd, 2'd0, 2'd1, stAddr), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd1, 2'd0, 2'd0, fnWwd), 1'b1, 1'b1, stored);
        // Taken BEQ to row 19, rows 17 and 18 must not emit
        addRow(encodeItype(opBeq, 2'd1, 2'd3, 8'd2), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd2, 2'd0, 2'd0, fnWwd), 1'b0, 1'b0, 16'h0);
        addRow(encodeRtype(2'd2, 2'd0, 2'd0, fnWwd), 1'b0, 1'b0, 16'h0);
        addRow(encodeItype(opBne, 2'd1, 2'd3, 8'd2), 1'b1, 1'b0, 16'h0);
        addRow(encodeItype(opAdi, 2'd0, 2'd2, 8'h5A), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd2, 2'd0, 2'd0, fnWwd), 1'b1, 1'b1, 16'h005A);
        // Jump over two stale WWDs to row 25
        addRow({opJmp, 12'd25}, 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd1, 2'd0, 2'd0, fnWwd), 1'b0, 1'b0, 16'h0);
        addRow(encodeRtype(2'd1, 2'd0, 2'd0, fnWwd), 1'b0, 1'b0, 16'h0);
        addRow(encodeItype(opAdi, 2'd2, 2'd2, 8'h01), 1'b1, 1'b0, 16'h0);
        addRow(encodeRtype(2'd2, 2'd0, 2'd0, fnWwd), 1'b1, 1'b1, 16'h005B);
        addRow(hltInstr, 1'b1, 1'b0, 16'h0);
    endtask

    // Each new outputPort value is the next WWD in program order
    always @(negedge Clk) begin
        if (rstN && outputPort !== lastPort) begin
            if (wwdSeen >= wwdExpected.size()) begin
                failRun("outputPort changed more often than the program has WWD results");
            end else begin
                checkValue("outputPort", outputPort, wwdExpected[wwdSeen]);
            end
            wwdSeen++;
            lastPort = outputPort;
        end
    end

    initial begin
        wait (rstN === 1'b1);
        forever begin
            @(posedge Clk);
            if (!halted) begin
                cycles++;
                if (cycles > timeoutLimit) begin
                    failRun("timeout: processor never halted");
                end
            end
        end
    end

    initial begin
        logic [15:0] haltPort;
        logic [15:0] haltCount;
        logic [7:0]  addr;
        void'($urandom(randSeed));
        for (int i = 0; i < memDepth; i++) begin
            initData[i] = 16'($urandom);
            shadow[i] = initData[i];
            // Unused words are R-type codes with an unknown func, so no-ops
            addr = 8'(i);
            imem[i] = {4'hF, addr[3:0], 2'b00, 2'b11, addr[7:4]};
        end
        ldAddr = 8'($urandom % 100);
        stAddr = 8'(100 + $urandom % 20);
        memReady = 1'b1;
        buildProgram();
        for (int i = 0; i < progInstr.size(); i++) begin
            imem[i] = progInstr[i];
            if (progRetires[i]) begin
                retiredCount++;
            end
            if (progWwd[i]) begin
                wwdExpected.push_back(progExpect[i]);
            end
        end
        timeoutLimit = 4 * retiredCount + timeoutMargin;

        wait (rstN === 1'b1);
        checkValue("halted", 16'(halted), 16'd0);
        checkValue("dmemRead", 16'(dmemRead), 16'd0);
        checkValue("dmemWrite", 16'(dmemWrite), 16'd0);
        checkValue("imemRead", 16'(imemRead), 16'd1);

        while (halted !== 1'b1) begin
            @(negedge Clk);
        end
        haltPort = outputPort;
        haltCount = numInst;
        repeat (10) begin
            @(negedge Clk);
            checkValue("halted", 16'(halted), 16'd1);
            checkValue("imemRead", 16'(imemRead), 16'd0);
            checkValue("outputPort", outputPort, haltPort);
            checkValue("numInst", numInst, haltCount);
        end
        checkValue("numInst", numInst, 16'(retiredCount));
        checkValue("wwdCount", 16'(wwdSeen), 16'(wwdExpected.size()));
        checkValue("dmemStoreWord", dmem[stAddr], shadow[stAddr]);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- filelist.f
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/controlUnit.sv
rtl/hazardUnit.sv
rtl/pipelineDatapath.sv
rtl/cpuTop.sv
dv/clockGen.sv
dv/cpuTb.sv

//--- rtl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  logic [3:0]                    opcode,
    input  logic [5:0]                    func,
    input  logic [cpuPkg::wordSize-1:0]   opA,
    input  logic [cpuPkg::wordSize-1:0]   opB,
    output logic [cpuPkg::wordSize-1:0]   result,
    output logic                          zero
);
    import cpuPkg::*;

    aluOpT               aluOp;
    logic                isWwd;
    logic [wordSize-1:0] opResult;

    always_comb begin
        aluOp = aluAdd;
        if (opcode == opRtype) begin
            case (func)
                fnAdd:   aluOp = aluAdd;
                fnSub:   aluOp = aluSub;
                fnAnd:   aluOp = aluAnd;
                fnOrr:   aluOp = aluOrr;
                default: aluOp = aluAdd;
            endcase
        end else if (opcode == opBne || opcode == opBeq) begin
            // Compare by subtraction
            aluOp = aluSub;
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd:  opResult = opA + opB;
            aluSub:  opResult = opA - opB;
            aluAnd:  opResult = opA & opB;
            default: opResult = opA | opB;
        endcase
    end

    assign isWwd = (opcode == opRtype) && (func == fnWwd);
    assign result = isWwd ? opA : opResult;
    assign zero = (opResult == '0);

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  logic [cpuPkg::wordSize-1:0]   instr,
    output logic [cpuPkg::ctlWidth-1:0]   controls,
    output logic                          useRs,
    output logic                          useRt
);
    import cpuPkg::*;

    logic [3:0] opcode;
    logic [5:0] func;

    assign opcode = instr[opcodeMsb:opcodeLsb];
    assign func = instr[funcMsb:funcLsb];

    always_comb begin
        controls = '0;
        useRs = 1'b0;
        useRt = 1'b0;
        case (opcode)
            opRtype: begin
                case (func)
                    fnAdd, fnSub, fnAnd, fnOrr: begin
                        controls[ctlRegWrite] = 1'b1;
                        useRs = 1'b1;
                        useRt = 1'b1;
                    end
                    fnWwd: begin
                        controls[ctlWwd] = 1'b1;
                        useRs = 1'b1;
                    end
                    fnHlt:   controls[ctlIsHalt] = 1'b1;
                    default: controls = '0;
                endcase
            end
            opAdi: begin
                controls[ctlRegWrite] = 1'b1;
                controls[ctlAluSrc] = 1'b1;
                useRs = 1'b1;
            end
            opLwd: begin
                controls[ctlRegWrite] = 1'b1;
                controls[ctlMemToReg] = 1'b1;
                controls[ctlMemRead] = 1'b1;
                controls[ctlAluSrc] = 1'b1;
                useRs = 1'b1;
            end
            opSwd: begin
                // rt carries the store data
                controls[ctlMemWrite] = 1'b1;
                controls[ctlAluSrc] = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            opBne, opBeq: begin
                controls[ctlIsBranch] = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            opJmp:   controls[ctlIsJump] = 1'b1;
            default: controls = '0;
        endcase
    end

endmodule

//--- rtl/cpuPkg.sv
package cpuPkg;

    localparam int wordSize = 16;

    // Instruction field positions
    localparam int opcodeMsb = 15;
    localparam int opcodeLsb = 12;
    localparam int rsMsb = 11;
    localparam int rsLsb = 10;
    localparam int rtMsb = 9;
    localparam int rtLsb = 8;
    localparam int rdMsb = 7;
    localparam int rdLsb = 6;
    localparam int funcMsb = 5;
    localparam int funcLsb = 0;
    localparam int immMsb = 7;
    localparam int immLsb = 0;
    localparam int targetMsb = 11;
    localparam int targetLsb = 0;

    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opRtype = 4'd15;

    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOrr} aluOpT;

    // Control bundle, writeback group lowest so each stage drops the top bits
    localparam int ctlWwd = 0;
    localparam int ctlRegWrite = 1;
    localparam int ctlMemToReg = 2;
    localparam int ctlIsHalt = 3;
    localparam int ctlMemWrite = 4;
    localparam int ctlMemRead = 5;
    localparam int ctlIsBranch = 6;
    localparam int ctlAluSrc = 7;
    localparam int ctlIsJump = 8;
    localparam int ctlWidth = 9;
    localparam int wbCtlWidth = 4;
    localparam int memCtlWidth = 6;
    localparam int exCtlWidth = 8;

    // Forwarding selects for the execute operands
    localparam logic [1:0] fwdNone = 2'd0;
    localparam logic [1:0] fwdMem = 2'd1;
    localparam logic [1:0] fwdWb = 2'd2;

    typedef logic [1:0] regAddrT;

endpackage

//--- rtl/cpuTop.sv
`timescale 1ns/10ps

module cpuTop (
    input  logic                          Clk,
    input  logic                          rstN,
    output logic                          imemRead,
    output logic [cpuPkg::wordSize-1:0]   imemAddr,
    input  logic [cpuPkg::wordSize-1:0]   imemData,
    output logic                          dmemRead,
    output logic                          dmemWrite,
    output logic [cpuPkg::wordSize-1:0]   dmemAddr,
    output logic [cpuPkg::wordSize-1:0]   dmemWdata,
    input  logic [cpuPkg::wordSize-1:0]   dmemRdata,
    output logic                          halted,
    output logic [cpuPkg::wordSize-1:0]   numInst,
    output logic [cpuPkg::wordSize-1:0]   outputPort
);
    import cpuPkg::*;

    logic [wordSize-1:0] idInstr;
    logic [ctlWidth-1:0] controls;
    logic                useRs;
    logic                useRt;
    regAddrT             idRs;
    regAddrT             idRt;
    regAddrT             exRs;
    regAddrT             exRt;
    regAddrT             exRd;
    regAddrT             memRd;
    regAddrT             wbRd;
    logic                exMemRead;
    logic                memRegWrite;
    logic                wbRegWrite;
    logic [1:0]          fwdA;
    logic [1:0]          fwdB;
    logic                stall;

    pipelineDatapath i_pipelineDatapath (.*);

    controlUnit i_controlUnit (
        .instr    (idInstr),
        .controls (controls),
        .useRs    (useRs),
        .useRt    (useRt)
    );

    hazardUnit i_hazardUnit (.*);

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  cpuPkg::regAddrT idRs,
    input  cpuPkg::regAddrT idRt,
    input  cpuPkg::regAddrT exRs,
    input  cpuPkg::regAddrT exRt,
    input  cpuPkg::regAddrT exRd,
    input  cpuPkg::regAddrT memRd,
    input  cpuPkg::regAddrT wbRd,
    input  logic            useRs,
    input  logic            useRt,
    input  logic            exMemRead,
    input  logic            memRegWrite,
    input  logic            wbRegWrite,
    output logic [1:0]      fwdA,
    output logic [1:0]      fwdB,
    output logic            stall
);
    import cpuPkg::*;

    // Younger result in memory stage wins over writeback
    assign fwdA = (memRegWrite && memRd == exRs) ? fwdMem :
                  (wbRegWrite && wbRd == exRs)   ? fwdWb  : fwdNone;
    assign fwdB = (memRegWrite && memRd == exRt) ? fwdMem :
                  (wbRegWrite && wbRd == exRt)   ? fwdWb  : fwdNone;

    // Load result is not ready until it reaches writeback
    assign stall = exMemRead && ((useRs && idRs == exRd) || (useRt && idRt == exRd));

endmodule

//--- rtl/pipelineDatapath.sv
`timescale 1ns/10ps

module pipelineDatapath (
    input  logic                          Clk,
    input  logic                          rstN,
    output logic                          imemRead,
    output logic [cpuPkg::wordSize-1:0]   imemAddr,
    input  logic [cpuPkg::wordSize-1:0]   imemData,
    output logic                          dmemRead,
    output logic                          dmemWrite,
    output logic [cpuPkg::wordSize-1:0]   dmemAddr,
    output logic [cpuPkg::wordSize-1:0]   dmemWdata,
    input  logic [cpuPkg::wordSize-1:0]   dmemRdata,
    output logic [cpuPkg::wordSize-1:0]   idInstr,
    input  logic [cpuPkg::ctlWidth-1:0]   controls,
    output cpuPkg::regAddrT               idRs,
    output cpuPkg::regAddrT               idRt,
    output cpuPkg::regAddrT               exRs,
    output cpuPkg::regAddrT               exRt,
    output cpuPkg::regAddrT               exRd,
    output logic                          exMemRead,
    output cpuPkg::regAddrT               memRd,
    output logic                          memRegWrite,
    output cpuPkg::regAddrT               wbRd,
    output logic                          wbRegWrite,
    input  logic [1:0]                    fwdA,
    input  logic [1:0]                    fwdB,
    input  logic                          stall,
    output logic                          halted,
    output logic [cpuPkg::wordSize-1:0]   numInst,
    output logic [cpuPkg::wordSize-1:0]   outputPort
);
    import cpuPkg::*;

    logic [wordSize-1:0]    pc;
    logic [wordSize-1:0]    ifIdPc;
    logic [wordSize-1:0]    ifIdInstr;
    logic                   ifIdBubble;

    logic [wordSize-1:0]    idExPc;
    logic [wordSize-1:0]    idExRdataA;
    logic [wordSize-1:0]    idExRdataB;
    logic [wordSize-1:0]    idExImm;
    logic [exCtlWidth-1:0]  idExCtl;
    regAddrT                idExRs;
    regAddrT                idExRt;
    regAddrT                idExDest;
    logic [3:0]             idExOpcode;
    logic [5:0]             idExFunc;
    logic                   idExBubble;

    logic [memCtlWidth-1:0] exMemCtl;
    logic [wordSize-1:0]    exMemAlu;
    logic [wordSize-1:0]    exMemStoreData;
    regAddrT                exMemDest;
    logic                   exMemBubble;

    logic [wbCtlWidth-1:0]  memWbCtl;
    logic [wordSize-1:0]    memWbAlu;
    logic [wordSize-1:0]    memWbLoad;
    regAddrT                memWbDest;
    logic                   memWbBubble;

    logic [3:0]             idOpcode;
    logic [wordSize-1:0]    idImm;
    logic [wordSize-1:0]    idRdataA;
    logic [wordSize-1:0]    idRdataB;
    logic [wordSize-1:0]    jumpTarget;
    regAddrT                idDest;
    logic                   idJump;

    logic [wordSize-1:0]    wbData;
    logic                   regWrEn;
    logic [wordSize-1:0]    exOpA;
    logic [wordSize-1:0]    exFwdB;
    logic [wordSize-1:0]    exOpB;
    logic [wordSize-1:0]    exResult;
    logic [wordSize-1:0]    branchTarget;
    logic                   exZero;
    logic                   branchTaken;

    // Decode
    assign idInstr = ifIdInstr;
    assign idOpcode = ifIdInstr[opcodeMsb:opcodeLsb];
    assign idRs = ifIdInstr[rsMsb:rsLsb];
    assign idRt = ifIdInstr[rtMsb:rtLsb];
    // R-type writes rd, ADI and LWD write rt
    assign idDest = (idOpcode == opRtype) ? ifIdInstr[rdMsb:rdLsb] : idRt;
    assign idImm = {{(wordSize-8){ifIdInstr[immMsb]}}, ifIdInstr[immMsb:immLsb]};
    assign jumpTarget = {ifIdPc[wordSize-1:targetMsb+1], ifIdInstr[targetMsb:targetLsb]};
    assign idJump = controls[ctlIsJump] && !ifIdBubble;

    assign wbData = memWbCtl[ctlMemToReg] ? memWbLoad : memWbAlu;
    assign regWrEn = memWbCtl[ctlRegWrite] && !halted;

    regFile i_regFile (
        .Clk     (Clk),
        .rstN    (rstN),
        .rdAddrA (idRs),
        .rdAddrB (idRt),
        .wrAddr  (memWbDest),
        .wrData  (wbData),
        .wrEn    (regWrEn),
        .rdDataA (idRdataA),
        .rdDataB (idRdataB)
    );

    // Execute operand muxes
    always_comb begin
        case (fwdA)
            fwdMem:  exOpA = exMemAlu;
            fwdWb:   exOpA = wbData;
            default: exOpA = idExRdataA;
        endcase
        case (fwdB)
            fwdMem:  exFwdB = exMemAlu;
            fwdWb:   exFwdB = wbData;
            default: exFwdB = idExRdataB;
        endcase
    end

    assign exOpB = idExCtl[ctlAluSrc] ? idExImm : exFwdB;

    aluUnit i_aluUnit (
        .opcode (idExOpcode),
        .func   (idExFunc),
        .opA    (exOpA),
        .opB    (exOpB),
        .result (exResult),
        .zero   (exZero)
    );

    assign branchTaken = idExCtl[ctlIsBranch] && ((idExOpcode == opBeq) ? exZero : !exZero);
    assign branchTarget = idExPc + 1'b1 + idExImm;

    assign exRs = idExRs;
    assign exRt = idExRt;
    assign exRd = idExDest;
    assign exMemRead = idExCtl[ctlMemRead];
    assign memRd = exMemDest;
    assign memRegWrite = exMemCtl[ctlRegWrite];
    assign wbRd = memWbDest;
    assign wbRegWrite = memWbCtl[ctlRegWrite];

    assign imemRead = !halted;
    assign imemAddr = pc;
    assign dmemRead = exMemCtl[ctlMemRead] && !halted;
    // Store behind a retiring HLT must not land
    assign dmemWrite = exMemCtl[ctlMemWrite] && !halted && !memWbCtl[ctlIsHalt];
    assign dmemAddr = exMemAlu;
    assign dmemWdata = exMemStoreData;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= '0;
            ifIdBubble <= 1'b1;
            idExBubble <= 1'b1;
            idExCtl <= '0;
            exMemBubble <= 1'b1;
            exMemCtl <= '0;
            memWbBubble <= 1'b1;
            memWbCtl <= '0;
            numInst <= '0;
            outputPort <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (!memWbBubble) begin
                numInst <= numInst + 1'b1;
                if (memWbCtl[ctlWwd]) begin
                    outputPort <= memWbAlu;
                end
                if (memWbCtl[ctlIsHalt]) begin
                    halted <= 1'b1;
                end
            end
            memWbBubble <= exMemBubble;
            memWbCtl <= exMemCtl[wbCtlWidth-1:0];
            exMemBubble <= idExBubble;
            exMemCtl <= idExCtl[memCtlWidth-1:0];
            // Bubble into execute on flush or load-use
            if (branchTaken || stall || ifIdBubble) begin
                idExBubble <= 1'b1;
                idExCtl <= '0;
            end else begin
                idExBubble <= 1'b0;
                idExCtl <= controls[exCtlWidth-1:0];
            end
            if (branchTaken) begin
                pc <= branchTarget;
                ifIdBubble <= 1'b1;
            end else if (!stall) begin
                pc <= idJump ? jumpTarget : pc + 1'b1;
                ifIdBubble <= idJump;
            end
        end
    end

    // Payload, qualified by the bubble flags above
    always_ff @(posedge Clk) begin
        if (!halted) begin
            memWbAlu <= exMemAlu;
            memWbLoad <= dmemRdata;
            memWbDest <= exMemDest;
            exMemAlu <= exResult;
            exMemStoreData <= exFwdB;
            exMemDest <= idExDest;
            idExPc <= ifIdPc;
            idExRdataA <= idRdataA;
            idExRdataB <= idRdataB;
            idExImm <= idImm;
            idExRs <= idRs;
            idExRt <= idRt;
            idExDest <= idDest;
            idExOpcode <= idOpcode;
            idExFunc <= ifIdInstr[funcMsb:funcLsb];
            if (!stall) begin
                ifIdPc <= pc;
                ifIdInstr <= imemData;
            end
        end
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                          Clk,
    input  logic                          rstN,
    input  cpuPkg::regAddrT               rdAddrA,
    input  cpuPkg::regAddrT               rdAddrB,
    input  cpuPkg::regAddrT               wrAddr,
    input  logic [cpuPkg::wordSize-1:0]   wrData,
    input  logic                          wrEn,
    output logic [cpuPkg::wordSize-1:0]   rdDataA,
    output logic [cpuPkg::wordSize-1:0]   rdDataB
);
    import cpuPkg::*;

    logic [wordSize-1:0] regs [4];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Same-cycle write shows through to decode
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds and runs cpuTb with Verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module cpuTb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VcpuTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Simulation finished: FAIL" "$logFile"; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0
